/* bench/clockGen.sv */
`timescale 1ns/100ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic nrst
);

    // 10 ns period, first rising edge at 5 ns
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset covers five rising edges and is released on a falling edge
    initial begin
        nrst = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
    end

endmodule

`default_nettype wire

/* bench/cpuTb.sv */
`timescale 1ns/100ps
`default_nettype none

module cpuTb
    import cpuPkg::*;
();

    localparam int cycleLimit = 2000;
    localparam int tailCycles = 12;
    localparam logic [dataWidth-1:0] poisonValue = 16'hDEAD;

    logic                 clk;
    logic                 nrst;
    logic                 memReady;
    logic [dataWidth-1:0] memRdata;
    memRequest            memReq;
    logic                 halted;

    logic [dataWidth-1:0] memory [0:63];
    logic                 poisonAt [0:63];
    logic [addrWidth-1:0] expAddr [$];
    logic [dataWidth-1:0] expData [$];
    logic [31:0]          lcgState;
    memRequest            prevReq;
    logic                 prevStall;
    logic                 firstEnabledSeen;
    logic                 firstReadSeen;
    logic                 haltSeen;
    int                   writeCount;
    int                   cycleCount;

    clockGen clocks (
        .clk  (clk),
        .nrst (nrst)
    );

    cpuTop uut (
        .clk      (clk),
        .nrst     (nrst),
        .memRdata (memRdata),
        .memReady (memReady),
        .memReq   (memReq),
        .halted   (halted)
    );

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] encodeInstr(input logic [5:0] op, input logic [3:0] am,
                                                input logic [5:0] fld);
        return {op, am, fld};
    endfunction

    task automatic announceFailure();
        $display("Test FAILED");
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
        announceFailure();
    endtask

    task automatic reportProblem(input string what);
        $display("ERROR: %s", what);
        announceFailure();
    endtask

    // program image, every word not used by the program carries its own address
    task automatic loadProgram();
        for (int i = 0; i < 64; i++) begin
            memory[i]   = 16'hA500 | 16'(i);
            poisonAt[i] = 1'b0;
        end
        memory[0]  = encodeInstr(opLda, amImmediate, 6'd5);
        memory[1]  = encodeInstr(opSta, amDirect, 6'd48);
        memory[2]  = encodeInstr(opLda, amDirect, 6'd40);
        memory[3]  = encodeInstr(opAdd, amImmediate, 6'd3);
        memory[4]  = encodeInstr(opAdd, amDirect, 6'd41);
        memory[5]  = encodeInstr(opSta, amIndirect, 6'd42);
        memory[6]  = encodeInstr(opSub, amDirect, 6'd43);
        memory[7]  = encodeInstr(opAnd, amDirect, 6'd44);
        memory[8]  = encodeInstr(opJz, amImmediate, 6'd11);
        memory[9]  = encodeInstr(opLda, amDirect, 6'd45);
        memory[10] = encodeInstr(opSta, amDirect, 6'd50);
        memory[11] = encodeInstr(opSta, amDirect, 6'd51);
        memory[12] = encodeInstr(opLda, amIndirect, 6'd46);
        memory[13] = encodeInstr(opJz, amImmediate, 6'd9);
        memory[14] = encodeInstr(opSta, amDirect, 6'd52);
        memory[15] = encodeInstr(opSub, amImmediate, 6'h25);
        memory[16] = encodeInstr(opJmp, amImmediate, 6'd19);
        memory[17] = encodeInstr(opLda, amDirect, 6'd45);
        memory[18] = encodeInstr(opSta, amDirect, 6'd53);
        memory[19] = encodeInstr(opSta, amIndirect, 6'd54);
        memory[20] = encodeInstr(opJmp, amDirect, 6'd22);
        memory[21] = encodeInstr(opLda, amDirect, 6'd45);
        // an implied store has no address and must not write
        memory[22] = encodeInstr(opSta, amImplied, 6'd56);
        memory[23] = encodeInstr(opNop, amImplied, 6'd0);
        memory[24] = encodeInstr(opHlt, amImplied, 6'd0);
        memory[40] = 16'h1234;
        memory[41] = 16'h0100;
        memory[42] = 16'd49;
        memory[43] = 16'h0337;
        memory[44] = 16'h0F00;
        memory[45] = poisonValue;
        memory[46] = 16'd47;
        memory[47] = 16'h00A5;
        memory[54] = 16'd55;
        // skipped code and the poison word are never touched
        poisonAt[9]  = 1'b1;
        poisonAt[10] = 1'b1;
        poisonAt[17] = 1'b1;
        poisonAt[18] = 1'b1;
        poisonAt[21] = 1'b1;
        poisonAt[45] = 1'b1;
    endtask

    // instruction level model of the program, it lists the stores in order
    task automatic runReference();
        logic [15:0] image [0:63];
        logic [5:0]  pc;
        logic [5:0]  ea;
        logic [5:0]  op;
        logic [5:0]  fld;
        logic [3:0]  am;
        logic [15:0] acc;
        logic [15:0] operand;
        logic        memMode;
        logic        done;
        int          steps;
        for (int i = 0; i < 64; i++) begin
            image[i] = memory[i];
        end
        pc    = '0;
        acc   = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 100) begin
            {op, am, fld} = image[pc];
            pc = pc + 6'd1;
            steps++;
            if (am > amIndirect) begin
                am = amImplied;
            end
            memMode = (am == amDirect) || (am == amIndirect);
            ea      = (am == amIndirect) ? image[fld][5:0] : fld;
            operand = memMode ? image[ea] : {10'd0, fld};
            case (op)
                opLda: acc = operand;
                opAdd: acc = acc + operand;
                opSub: acc = acc - operand;
                opAnd: acc = acc & operand;
                opSta: begin
                    if (memMode) begin
                        image[ea] = acc;
                        expAddr.push_back(ea);
                        expData.push_back(acc);
                    end
                end
                opJmp: pc = memMode ? ea : fld;
                opJz: begin
                    if (acc == '0) begin
                        pc = memMode ? ea : fld;
                    end
                end
                opHlt: done = 1'b1;
                default: ;
            endcase
        end
    endtask

    // ----------------------------------------------------------------------
    // memory model, reads are combinational and writes land on the clock
    // ----------------------------------------------------------------------
    assign memRdata = memory[memReq.addr];

    always @(posedge clk) begin
        if (nrst && memReq.write && memReady) begin
            memory[memReq.addr] <= memReq.wdata;
        end
    end

    // ----------------------------------------------------------------------
    // checks, sampled at the rising edge before any register moves
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        if (!nrst) begin
            assert (!memReq.read && !memReq.write && !halted) else begin
                reportMismatch("resetQuiet", 0, {memReq.read, memReq.write, halted});
                $fatal(1);
            end
            prevStall        <= 1'b0;
            firstEnabledSeen <= 1'b0;
            firstReadSeen    <= 1'b0;
            haltSeen         <= 1'b0;
            writeCount       <= 0;
        end else begin
            if (memReady && !firstEnabledSeen) begin
                assert (!memReq.read && !memReq.write && !halted) else begin
                    reportMismatch("firstCycle", 0, {memReq.read, memReq.write, halted});
                    $fatal(1);
                end
                firstEnabledSeen <= 1'b1;
            end
            if (memReq.read && !firstReadSeen) begin
                assert (memReq.addr == '0) else begin
                    reportMismatch("firstRead", 0, memReq.addr);
                    $fatal(1);
                end
                firstReadSeen <= 1'b1;
            end
            // a stalled edge must leave the request as it was
            if (prevStall) begin
                assert (memReq == prevReq) else begin
                    reportMismatch("stallStable", prevReq, memReq);
                    $fatal(1);
                end
            end
            if (memReq.read) begin
                assert (!poisonAt[memReq.addr]) else begin
                    reportProblem($sformatf("read of skipped location %0d", memReq.addr));
                    $fatal(1);
                end
            end
            if (memReq.write && memReady) begin
                assert (writeCount < expAddr.size()) else begin
                    reportProblem("the CPU stored more words than the program holds");
                    $fatal(1);
                end
                assert (memReq.wdata != poisonValue) else begin
                    reportProblem("a store carried the poison value");
                    $fatal(1);
                end
                assert (memReq.addr == expAddr[writeCount]) else begin
                    reportMismatch("storeAddr", expAddr[writeCount], memReq.addr);
                    $fatal(1);
                end
                assert (memReq.wdata == expData[writeCount]) else begin
                    reportMismatch("storeData", expData[writeCount], memReq.wdata);
                    $fatal(1);
                end
                writeCount <= writeCount + 1;
            end
            if (haltSeen) begin
                assert (halted) else begin
                    reportMismatch("haltSticky", 1, halted);
                    $fatal(1);
                end
            end
            if (halted) begin
                assert (!memReq.read && !memReq.write) else begin
                    reportMismatch("haltQuiet", 0, {memReq.read, memReq.write});
                    $fatal(1);
                end
                haltSeen <= 1'b1;
            end
            prevStall <= !memReady;
            prevReq   <= memReq;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            reportProblem($sformatf("halt was never reached within %0d cycles", cycleLimit));
            $fatal(1);
        end
    end

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    initial begin
        cycleCount = 0;
        memReady   = 1'b1;
        lcgState   = 32'h04b591da;
        loadProgram();
        runReference();
        @(posedge nrst);
        // about one cycle in four is stalled
        while (!haltSeen) begin
            @(negedge clk);
            lcgState = nextRandom(lcgState);
            memReady = (lcgState[31:30] != 2'b00);
        end
        repeat (tailCycles) begin
            @(negedge clk);
            lcgState = nextRandom(lcgState);
            memReady = (lcgState[31:30] != 2'b00);
        end
        if (writeCount == expAddr.size()) begin
            $display("Test OK");
            $finish;
        end else begin
            reportMismatch("storeCount", expAddr.size(), writeCount);
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* list.f */
rtl/cpuPkg.sv
rtl/timingPkg.sv
rtl/instructionDecoder.sv
rtl/stateMachine.sv
rtl/controlUnit.sv
rtl/datapath.sv
rtl/cpuTop.sv
bench/clockGen.sv
bench/cpuTb.sv

/* rtl/controlUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module controlUnit
    import cpuPkg::*;
    import timingPkg::*;
(
    input  phaseMode                    mode,
    input  timingPkg::timeState         timeState,
    input  wire logic [opcodeWidth-1:0] opcode,
    input  wire logic [modeWidth-1:0]   addrMode,
    input  wire logic                   accZero,
    output controlWord                  ctrl,
    output logic                        noAddressing,
    output logic                        endAddressing,
    output logic                        getInstruction
);

    logic memOperand;
    aluOp opAlu;

    // direct and indirect modes leave the operand address in the MAR
    assign memOperand = (addrMode == amDirect) || (addrMode == amIndirect);

    always_comb begin
        case (opcode)
            opAdd:   opAlu = aluAdd;
            opSub:   opAlu = aluSub;
            opAnd:   opAlu = aluAnd;
            default: opAlu = aluPass;
        endcase
    end

    // ----------------------------------------------------------------------
    // microsequence table
    // ----------------------------------------------------------------------
    always_comb begin
        ctrl          = '0;
        ctrl.aluSel   = aluPass;
        noAddressing  = 1'b0;
        endAddressing = 1'b0;

        if (mode == ADDRESS) begin
            // every addressing mode resolves in a single step
            if (timeState == T0) begin
                case (addrMode)
                    amDirect: begin
                        ctrl.loadMar  = 1'b1;
                        endAddressing = 1'b1;
                    end
                    amIndirect: begin
                        // the pointer word sits at the field address
                        ctrl.loadMar       = 1'b1;
                        ctrl.marFromMemory = 1'b1;
                        endAddressing      = 1'b1;
                    end
                    default: noAddressing = 1'b1;
                endcase
            end
        end else begin
            case (opcode)
                opLda, opAdd, opSub, opAnd: begin
                    if (timeState == T0) begin
                        ctrl.loadAcc           = 1'b1;
                        ctrl.readOperand       = memOperand;
                        ctrl.operandFromMemory = memOperand;
                        ctrl.aluSel            = opAlu;
                    end else if (timeState == T1) begin
                        ctrl.fetch = 1'b1;
                    end
                end
                opSta: begin
                    // a store needs an address, implied and immediate write nothing
                    if (timeState == T0) begin
                        ctrl.writeMem = memOperand;
                    end else if (timeState == T1) begin
                        ctrl.fetch = 1'b1;
                    end
                end
                opJmp: begin
                    if (timeState == T0) begin
                        ctrl.loadPc    = 1'b1;
                        ctrl.pcFromMar = memOperand;
                    end else if (timeState == T1) begin
                        ctrl.fetch = 1'b1;
                    end
                end
                opJz: begin
                    if (timeState == T0) begin
                        ctrl.loadPc    = accZero;
                        ctrl.pcFromMar = memOperand;
                    end else if (timeState == T1) begin
                        ctrl.fetch = 1'b1;
                    end
                end
                opHlt: begin
                    // no fetch, the time state just keeps wrapping
                    ctrl.halted = 1'b1;
                end
                default: begin
                    // NOP and anything the decoder turned into one
                    if (timeState == T0) begin
                        ctrl.fetch = 1'b1;
                    end
                end
            endcase
        end

        getInstruction = ctrl.fetch;
    end

    // the single memory port cannot store and fetch in the same cycle
    noWriteOnFetch: assert final (ctrl.writeMem !== 1'b1 || ctrl.fetch !== 1'b1);

endmodule

`default_nettype wire

/* rtl/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    // ----------------------------------------------------------------------
    // word and field widths
    // ----------------------------------------------------------------------
    localparam int dataWidth   = 16;
    localparam int addrWidth   = 6;
    localparam int opcodeWidth = 6;
    localparam int modeWidth   = 4;

    // ----------------------------------------------------------------------
    // instruction set
    // ----------------------------------------------------------------------
    localparam logic [opcodeWidth-1:0] opNop = 6'd0;
    localparam logic [opcodeWidth-1:0] opLda = 6'd1;
    localparam logic [opcodeWidth-1:0] opSta = 6'd2;
    localparam logic [opcodeWidth-1:0] opAdd = 6'd3;
    localparam logic [opcodeWidth-1:0] opSub = 6'd4;
    localparam logic [opcodeWidth-1:0] opAnd = 6'd5;
    localparam logic [opcodeWidth-1:0] opJmp = 6'd6;
    localparam logic [opcodeWidth-1:0] opJz  = 6'd7;
    localparam logic [opcodeWidth-1:0] opHlt = 6'd63;

    // addressing modes, anything above indirect is undefined
    localparam logic [modeWidth-1:0] amImplied   = 4'd0;
    localparam logic [modeWidth-1:0] amImmediate = 4'd1;
    localparam logic [modeWidth-1:0] amDirect    = 4'd2;
    localparam logic [modeWidth-1:0] amIndirect  = 4'd3;

    // the field order matches the bit order of the instruction word
    typedef struct packed {
        logic [opcodeWidth-1:0] opcode;
        logic [modeWidth-1:0]   mode;
        logic [addrWidth-1:0]   field;
    } decodedInstr;

    typedef enum logic [1:0] {
        aluPass = 2'd0,
        aluAdd  = 2'd1,
        aluSub  = 2'd2,
        aluAnd  = 2'd3
    } aluOp;

    // one cycle worth of datapath control
    typedef struct packed {
        logic fetch;
        logic loadMar;
        logic marFromMemory;
        logic readOperand;
        logic operandFromMemory;
        logic loadAcc;
        aluOp aluSel;
        logic writeMem;
        logic loadPc;
        logic pcFromMar;
        logic halted;
    } controlWord;

    typedef struct packed {
        logic [addrWidth-1:0] addr;
        logic                 read;
        logic                 write;
        logic [dataWidth-1:0] wdata;
    } memRequest;

endpackage

`default_nettype wire

/* rtl/cpuTop.sv */
`timescale 1ns/100ps
`default_nettype none

module cpuTop
    import cpuPkg::*;
    import timingPkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 nrst,
    input  wire logic [dataWidth-1:0] memRdata,
    input  wire logic                 memReady,
    output memRequest                 memReq,
    output logic                      halted
);

    decodedInstr            decoded;
    controlWord             ctrl;
    phaseMode               phase;
    timingPkg::timeState    tState;
    logic [opcodeWidth-1:0] currentOpcode;
    logic [modeWidth-1:0]   currentMode;
    logic                   noAddressing;
    logic                   endAddressing;
    logic                   getInstruction;
    logic                   accZero;

    // the decoder watches the read data all the time, it only matters on a fetch
    instructionDecoder decoder (
        .instrWord (memRdata),
        .decoded   (decoded)
    );

    stateMachine sequencer (
        .clk            (clk),
        .nrst           (nrst),
        .noAddressing   (noAddressing),
        .getInstruction (getInstruction),
        .endAddressing  (endAddressing),
        .enableFFs      (memReady),
        .decodedOpcode  (decoded.opcode),
        .decodedMode    (decoded.mode),
        .currentOpcode  (currentOpcode),
        .currentMode    (currentMode),
        .timeState      (tState),
        .mode           (phase)
    );

    controlUnit control (
        .mode           (phase),
        .timeState      (tState),
        .opcode         (currentOpcode),
        .addrMode       (currentMode),
        .accZero        (accZero),
        .ctrl           (ctrl),
        .noAddressing   (noAddressing),
        .endAddressing  (endAddressing),
        .getInstruction (getInstruction)
    );

    datapath dp (
        .clk      (clk),
        .nrst     (nrst),
        .enable   (memReady),
        .ctrl     (ctrl),
        .field    (decoded.field),
        .memRdata (memRdata),
        .memReq   (memReq),
        .accZero  (accZero)
    );

    assign halted = ctrl.halted;

endmodule

`default_nettype wire

/* rtl/datapath.sv */
`timescale 1ns/100ps
`default_nettype none

module datapath
    import cpuPkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 nrst,
    input  wire logic                 enable,
    input  controlWord                ctrl,
    input  wire logic [addrWidth-1:0] field,
    input  wire logic [dataWidth-1:0] memRdata,
    output memRequest                 memReq,
    output logic                      accZero
);

    logic [addrWidth-1:0] pc;
    logic [addrWidth-1:0] mar;
    logic [addrWidth-1:0] fieldReg;
    logic [dataWidth-1:0] acc;
    logic [dataWidth-1:0] operand;
    logic [dataWidth-1:0] aluResult;

    // ----------------------------------------------------------------------
    // operand select and ALU
    // ----------------------------------------------------------------------
    assign operand = ctrl.operandFromMemory ? memRdata : dataWidth'(fieldReg);

    // results wrap at the word width
    always_comb begin
        case (ctrl.aluSel)
            aluAdd:  aluResult = acc + operand;
            aluSub:  aluResult = acc - operand;
            aluAnd:  aluResult = acc & operand;
            default: aluResult = operand;
        endcase
    end

    assign accZero = (acc == '0);

    // ----------------------------------------------------------------------
    // registers, all frozen while the memory is not ready
    // ----------------------------------------------------------------------
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            pc       <= '0;
            mar      <= '0;
            fieldReg <= '0;
            acc      <= '0;
        end else if (enable) begin
            if (ctrl.fetch) begin
                pc       <= pc + addrWidth'(1);
                fieldReg <= field;
            end else if (ctrl.loadPc) begin
                pc <= ctrl.pcFromMar ? mar : fieldReg;
            end
            if (ctrl.loadMar) begin
                // for indirect mode the low bits of the pointer word are the address
                mar <= ctrl.marFromMemory ? memRdata[addrWidth-1:0] : fieldReg;
            end
            if (ctrl.loadAcc) begin
                acc <= aluResult;
            end
        end
    end

    // ----------------------------------------------------------------------
    // memory request, built from registered state only
    // ----------------------------------------------------------------------
    always_comb begin
        if (ctrl.fetch) begin
            memReq.addr = pc;
        end else if (ctrl.marFromMemory) begin
            memReq.addr = fieldReg;
        end else begin
            memReq.addr = mar;
        end
        memReq.read  = ctrl.fetch || ctrl.readOperand || ctrl.marFromMemory;
        memReq.write = ctrl.writeMem;
        memReq.wdata = acc;
    end

    readWriteExclusive: assert property (@(posedge clk) disable iff (!nrst)
        !(memReq.read && memReq.write));

    // a stall must leave the request untouched for the memory
    stableWhileStalled: assert property (@(posedge clk) disable iff (!nrst)
        !enable |=> $stable(memReq));

endmodule

`default_nettype wire

/* rtl/instructionDecoder.sv */
`timescale 1ns/100ps
`default_nettype none

module instructionDecoder
    import cpuPkg::*;
(
    input  wire logic [dataWidth-1:0] instrWord,
    output decodedInstr               decoded
);

    decodedInstr rawFields;

    // the packed struct follows the word layout, so a cast splits it
    assign rawFields = decodedInstr'(instrWord);

    always_comb begin
        decoded = rawFields;

        // unknown opcodes fall back to NOP so the CPU just moves on
        case (rawFields.opcode)
            opNop, opLda, opSta, opAdd, opSub, opAnd, opJmp, opJz, opHlt: ;
            default: decoded.opcode = opNop;
        endcase

        // unknown modes behave as implied, no memory access for the operand
        if (rawFields.mode > amIndirect) begin
            decoded.mode = amImplied;
        end
    end

endmodule

`default_nettype wire

/* rtl/stateMachine.sv */
`timescale 1ns/100ps
`default_nettype none

module stateMachine
    import cpuPkg::*;
    import timingPkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   nrst,
    input  wire logic                   noAddressing,
    input  wire logic                   getInstruction,
    input  wire logic                   endAddressing,
    input  wire logic                   enableFFs,
    input  wire logic [opcodeWidth-1:0] decodedOpcode,
    input  wire logic [modeWidth-1:0]   decodedMode,
    output logic [opcodeWidth-1:0]      currentOpcode,
    output logic [modeWidth-1:0]        currentMode,
    output timingPkg::timeState         timeState,
    output phaseMode                    mode
);

    phaseMode               nextMode;
    timingPkg::timeState    nextTime;
    logic [opcodeWidth-1:0] nextOpcode;
    logic [modeWidth-1:0]   nextAddrMode;

    // ----------------------------------------------------------------------
    // phase and time state sequencing
    // ----------------------------------------------------------------------
    always_comb begin
        nextMode = mode;
        nextTime = timeState;

        if (endAddressing || noAddressing) begin
            // addressing is done, start executing
            nextMode = INSTRUCTION;
            nextTime = T0;
        end else if (getInstruction) begin
            // the next instruction has been fetched
            nextMode = ADDRESS;
            nextTime = T0;
        end else begin
            case (timeState)
                T0:      nextTime = T1;
                T1:      nextTime = T2;
                T2:      nextTime = T3;
                T3:      nextTime = T4;
                T4:      nextTime = T5;
                T5:      nextTime = T6;
                default: nextTime = T0;
            endcase
        end

        // a stalled memory freezes the whole sequence
        if (!enableFFs) begin
            nextMode = mode;
            nextTime = timeState;
        end
    end

    // the opcode and mode are only captured together with a fetch
    always_comb begin
        nextOpcode   = currentOpcode;
        nextAddrMode = currentMode;
        if (getInstruction && enableFFs) begin
            nextOpcode   = decodedOpcode;
            nextAddrMode = decodedMode;
        end
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            mode      <= ADDRESS;
            timeState <= T0;
        end else begin
            mode      <= nextMode;
            timeState <= nextTime;
        end
    end

    // reset looks like a NOP so the first cycles fetch from address 0
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            currentOpcode <= opNop;
            currentMode   <= amImplied;
        end else begin
            currentOpcode <= nextOpcode;
            currentMode   <= nextAddrMode;
        end
    end

    // ----------------------------------------------------------------------
    // checks on the strobes coming from the control unit
    // ----------------------------------------------------------------------
    exclusiveEnd: assert property (@(posedge clk) disable iff (!nrst)
        !(noAddressing && endAddressing));

    fetchInInstruction: assert property (@(posedge clk) disable iff (!nrst)
        getInstruction |-> mode == INSTRUCTION);

endmodule

`default_nettype wire

/* rtl/timingPkg.sv */
`default_nettype none

package timingPkg;

    // time states inside a phase, the counter wraps after T6
    typedef enum logic [2:0] {
        T0 = 3'd0,
        T1 = 3'd1,
        T2 = 3'd2,
        T3 = 3'd3,
        T4 = 3'd4,
        T5 = 3'd5,
        T6 = 3'd6
    } timeState;

    // every instruction runs an address phase and then an instruction phase
    typedef enum logic {
        ADDRESS     = 1'b0,
        INSTRUCTION = 1'b1
    } phaseMode;

endpackage

`default_nettype wire
